/* revoke_sweep.f */
rtl/sweep_pkg.sv
rtl/sweep_walker.sv
rtl/sweep_entry_queue.sv
rtl/sweep_mem_sched.sv
rtl/sweep_top.sv
verif/sweep_mem_model.sv
verif/tb_sweep.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the revocation sweeper testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_sweep \
  -f revoke_sweep.f \
  --Mdir obj_dir \
  -o sim_tb_sweep
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "build failed with status ${build_status}"
  exit ${build_status}
fi

./obj_dir/sim_tb_sweep
run_status=$?
if [ ${run_status} -ne 0 ]; then
  echo "simulation failed with status ${run_status}"
  exit ${run_status}
fi

echo "simulation finished with status 0"
exit 0

/* verif/tb_sweep.sv */
// **************************************************
// revocation sweeper testbench
// directed sweeps against a capability memory model
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_sweep;

  import sweep_pkg::*;

  localparam int unsigned QueueDepth = 4;
  localparam int NumTests = 6;
  localparam int WindowGranules = 64;
  localparam int CyclesPerGranule = 40;
  localparam int TimeoutCycles = NumTests * WindowGranules * CyclesPerGranule;

  logic        clk_i;
  logic        rst_ni;
  logic        go_i;
  logic [31:0] start_addr_i;
  logic [31:0] end_addr_i;
  logic        busy_o;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  cap_word_t   mem_wdata_o;
  logic        mem_done_i;
  logic        mem_rsp_valid_i;
  logic        mem_rsp_is_wr_i;
  cap_word_t   mem_rsp_data_i;
  logic        mem_rsp_err_i;
  logic        mem_rsp_revoke_i;
  logic        snoop_done_i;
  logic        snoop_we_i;
  logic [31:0] snoop_addr_i;
  logic [3:0]  max_delay;

  // expected image and in-flight bookkeeping per granule
  cap_word_t init_word [64];
  logic      init_rev  [64];
  logic      init_err  [64];
  logic      pending   [64];
  logic      snooped   [64];
  gaddr_t    exp_next;
  gaddr_t    hold_gaddr;
  logic      hold_q;
  logic      hold_we;
  int        loads;
  int        pops;
  int        cycle_cnt;
  int        seed = 98977;
  int        img_seed;

  sweep_top #(
    .QueueDepth(QueueDepth)
  ) u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .go_i(go_i),
    .start_addr_i(start_addr_i), .end_addr_i(end_addr_i), .busy_o(busy_o),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_done_i(mem_done_i),
    .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_is_wr_i(mem_rsp_is_wr_i),
    .mem_rsp_data_i(mem_rsp_data_i), .mem_rsp_err_i(mem_rsp_err_i),
    .mem_rsp_revoke_i(mem_rsp_revoke_i), .snoop_done_i(snoop_done_i),
    .snoop_we_i(snoop_we_i), .snoop_addr_i(snoop_addr_i)
  );

  sweep_mem_model u_mem (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(mem_req_o), .we_i(mem_we_o),
    .addr_i(mem_addr_o), .wdata_i(mem_wdata_o), .max_delay_i(max_delay),
    .done_o(mem_done_i), .rsp_valid_o(mem_rsp_valid_i), .rsp_is_wr_o(mem_rsp_is_wr_i),
    .rsp_data_o(mem_rsp_data_i), .rsp_err_o(mem_rsp_err_i), .rsp_revoke_o(mem_rsp_revoke_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("** Error at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  task automatic check_gaddr(input string name, input gaddr_t got, input gaddr_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_cap(input string name, input cap_word_t got, input cap_word_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TimeoutCycles) begin
      stop_with_error($sformatf("timeout: sweeps did not finish within %0d cycles", TimeoutCycles));
    end
  end

  // bus monitor, sampled on the rising edge
  always @(posedge clk_i) begin
    logic [5:0] mi;
    logic [5:0] si;
    mi = mem_addr_o[8:3];
    si = snoop_addr_i[8:3];
    if (rst_ni) begin
      // a snooped store may withdraw a stalled write-back
      if (hold_q && !(hold_we && snoop_done_i && snoop_we_i)) begin
        check_bit("mem_req_o", mem_req_o, 1'b1);
        check_bit("mem_we_o", mem_we_o, hold_we);
        check_gaddr("mem_addr_o", mem_addr_o[31:3], hold_gaddr);
      end
      hold_q     = mem_req_o && !mem_done_i;
      hold_we    = mem_we_o;
      hold_gaddr = mem_addr_o[31:3];
      if (mem_req_o && mem_done_i && !mem_we_o) begin
        check_gaddr("mem_addr_o", mem_addr_o[31:3], exp_next);
        exp_next    = exp_next + 1'b1;
        loads       = loads + 1;
        pending[mi] = 1'b1;
        snooped[mi] = 1'b0;
      end
      if (mem_req_o && mem_done_i && mem_we_o) begin
        check_bit("busy_o", busy_o, 1'b1);
        check_bit($sformatf("snooped[%0d]", mi), snooped[mi], 1'b0);
        check_cap("mem_wdata_o", mem_wdata_o, {1'b0, init_word[mi][31:0]});
        pending[mi] = 1'b0;
      end
      if (snoop_done_i && snoop_we_i && pending[si]) begin
        snooped[si] = 1'b1;
      end
      if (u_dut.pop) begin
        pops = pops + 1;
      end
      check_bit("loads in flight within depth", (loads - pops) <= int'(QueueDepth), 1'b1);
    end
  end

  task automatic prepare_image(input logic with_err);
    logic [31:0] r;
    logic        tag;
    for (int i = 0; i < 64; i++) begin
      r   = $random(seed);
      tag = r[0] | (with_err && (i % 4 == 1));
      init_word[i] = {tag, 32'hA500_0000 ^ (32'(i) * 32'h0001_0203)};
      init_rev[i]  = r[2] | (with_err && (i % 4 == 1));
      init_err[i]  = with_err && (r[3] || (i % 4 == 1));
      pending[i]   = 1'b0;
      snooped[i]   = 1'b0;
      u_mem.preset(i, init_word[i], init_rev[i], init_err[i]);
    end
    u_mem.clear_log();
  endtask

  task automatic run_sweep(input int first, input int last);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("mem_req_o", mem_req_o, 1'b0);
    exp_next     = gaddr_t'(first);
    start_addr_i = 32'(first * 8);
    end_addr_i   = 32'(last * 8 + 7);
    go_i         = 1'b1;
    @(posedge clk_i);
    #1;
    go_i = 1'b0;
    check_bit("busy_o", busy_o, 1'b1);
    while (busy_o) begin
      @(posedge clk_i);
      #1;
    end
    check_gaddr("last granule loaded", exp_next, gaddr_t'(last + 1));
    // port stays quiet once the sweep is over
    repeat (20) begin
      @(posedge clk_i);
      #1;
      check_bit("mem_req_o", mem_req_o, 1'b0);
    end
  endtask

  task automatic verify_range(input int first, input int last);
    logic      qual;
    cap_word_t exp;
    for (int i = 0; i < 64; i++) begin
      qual = (i >= first) && (i <= last) && init_word[i][32] && init_rev[i]
             && !init_err[i] && !snooped[i];
      exp  = qual ? {1'b0, init_word[i][31:0]} : init_word[i];
      check_bit($sformatf("written[%0d]", i), u_mem.written[i], qual);
      check_cap($sformatf("mem[%0d]", i), u_mem.mem_q[i], exp);
    end
  endtask

  // stores to the granule just loaded and the one about to be loaded
  task automatic drive_snoops(input int count);
    for (int k = 0; k < count; k++) begin
      @(posedge clk_i);
      #1;
      snoop_done_i = 1'b1;
      snoop_we_i   = (k % 5 != 3);
      snoop_addr_i = (k % 2 == 0) ? {exp_next - 1'b1, 3'b100} : {exp_next, 3'b000};
    end
    @(posedge clk_i);
    #1;
    snoop_done_i = 1'b0;
    snoop_we_i   = 1'b0;
  endtask

  task automatic test_basic();
    max_delay = 4'd2;
    img_seed  = seed;
    prepare_image(1'b0);
    run_sweep(8, 23);
    verify_range(8, 23);
  endtask

  task automatic test_status();
    max_delay = 4'd1;
    prepare_image(1'b0);
    run_sweep(0, 5);
    verify_range(0, 5);
  endtask

  task automatic test_errors();
    max_delay = 4'd2;
    prepare_image(1'b1);
    run_sweep(16, 47);
    verify_range(16, 47);
  endtask

  task automatic test_snoop();
    logic any_hit;
    max_delay = 4'd3;
    any_hit   = 1'b0;
    prepare_image(1'b0);
    fork
      run_sweep(24, 39);
      drive_snoops(40);
    join
    for (int i = 24; i <= 39; i++) begin
      any_hit = any_hit | snooped[i];
    end
    check_bit("snoop hit a queued granule", any_hit, 1'b1);
    verify_range(24, 39);
  endtask

  task automatic test_backpressure();
    max_delay = 4'd12;
    seed      = img_seed;
    prepare_image(1'b0);
    run_sweep(8, 23);
    verify_range(8, 23);
  endtask

  task automatic test_single();
    max_delay = 4'd3;
    prepare_image(1'b0);
    init_word[40][32] = 1'b1;
    init_rev[40]      = 1'b1;
    u_mem.preset(40, init_word[40], 1'b1, 1'b0);
    run_sweep(40, 40);
    check_bit("one write-back", u_mem.wr_cnt == 1, 1'b1);
    verify_range(40, 40);
  endtask

  initial begin
    rst_ni       = 1'b0;
    go_i         = 1'b0;
    start_addr_i = '0;
    end_addr_i   = '0;
    snoop_done_i = 1'b0;
    snoop_we_i   = 1'b0;
    snoop_addr_i = '0;
    max_delay    = '0;
    hold_q       = 1'b0;
    hold_we      = 1'b0;
    hold_gaddr   = '0;
    exp_next     = '0;
    loads        = 0;
    pops         = 0;
    cycle_cnt    = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("mem_req_o", mem_req_o, 1'b0);
    check_bit("mem_we_o", mem_we_o, 1'b0);
    test_basic();
    test_status();
    test_errors();
    test_snoop();
    test_backpressure();
    test_single();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/sweep_mem_model.sv */
// **************************************************
// single-port capability memory model
// tags, revocation bits, error flags, random grants
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module sweep_mem_model (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [31:0]          addr_i,
  input  sweep_pkg::cap_word_t wdata_i,
  input  logic [3:0]           max_delay_i,
  output logic                 done_o,
  output logic                 rsp_valid_o,
  output logic                 rsp_is_wr_o,
  output sweep_pkg::cap_word_t rsp_data_o,
  output logic                 rsp_err_o,
  output logic                 rsp_revoke_o
);

  import sweep_pkg::*;

  // 64-granule window, byte address bits 8:3
  cap_word_t  mem_q   [64];
  logic       rev_q   [64];
  logic       err_q   [64];
  logic       written [64];
  int         wr_cnt;
  int         seed = 98977;

  logic [3:0] gnt_cnt_q;
  logic [1:0] rsp_cnt_q;
  logic       pending_q;

  assign done_o = req_i && !pending_q && (gnt_cnt_q == '0);

  task automatic preset(input int idx, input cap_word_t w, input logic rev, input logic err);
    mem_q[idx] = w;
    rev_q[idx] = rev;
    err_q[idx] = err;
  endtask

  task automatic clear_log();
    for (int i = 0; i < 64; i++) begin
      written[i] = 1'b0;
    end
    wr_cnt = 0;
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    logic [5:0]  idx;
    int unsigned ru;
    if (!rst_ni) begin
      gnt_cnt_q    <= '0;
      rsp_cnt_q    <= '0;
      pending_q    <= 1'b0;
      rsp_valid_o  <= 1'b0;
      rsp_is_wr_o  <= 1'b0;
      rsp_data_o   <= '0;
      rsp_err_o    <= 1'b0;
      rsp_revoke_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (gnt_cnt_q != '0) begin
        gnt_cnt_q <= gnt_cnt_q - 1'b1;
      end
      if (done_o) begin
        idx = addr_i[8:3];
        ru  = $random(seed);
        pending_q    <= 1'b1;
        rsp_cnt_q    <= {1'b0, ru[8]};
        gnt_cnt_q    <= 4'(ru % (32'(max_delay_i) + 32'd1));
        rsp_is_wr_o  <= we_i;
        rsp_data_o   <= mem_q[idx];
        rsp_err_o    <= err_q[idx];
        rsp_revoke_o <= rev_q[idx];
        if (we_i) begin
          mem_q[idx]   = wdata_i;
          written[idx] = 1'b1;
          wr_cnt       = wr_cnt + 1;
          $display("[%0t] mem write granule %0d data %h", $time, idx, wdata_i);
        end
      end else if (pending_q) begin
        // response one or two cycles after the grant
        if (rsp_cnt_q == '0) begin
          rsp_valid_o <= 1'b1;
          pending_q   <= 1'b0;
        end else begin
          rsp_cnt_q <= rsp_cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/sweep_top.sv */
// **************************************************
// revocation sweeper top level
// walker, entry queue and memory scheduler
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module sweep_top #(
  parameter int unsigned QueueDepth = sweep_pkg::DefaultQueueDepth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 go_i,
  input  logic [31:0]          start_addr_i,
  input  logic [31:0]          end_addr_i,
  output logic                 busy_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [31:0]          mem_addr_o,
  output sweep_pkg::cap_word_t mem_wdata_o,
  input  logic                 mem_done_i,
  input  logic                 mem_rsp_valid_i,
  input  logic                 mem_rsp_is_wr_i,
  input  sweep_pkg::cap_word_t mem_rsp_data_i,
  input  logic                 mem_rsp_err_i,
  input  logic                 mem_rsp_revoke_i,
  input  logic                 snoop_done_i,
  input  logic                 snoop_we_i,
  input  logic [31:0]          snoop_addr_i
);

  import sweep_pkg::*;

  logic      busy;
  logic      load_valid;
  gaddr_t    load_gaddr;
  logic      load_gnt;
  logic      credit;
  logic      queue_empty;
  logic      push;
  gaddr_t    push_gaddr;
  logic      rsp_wr;
  cap_word_t rsp_data;
  logic      rsp_err;
  logic      rsp_revoke;
  logic      pop;
  logic      head_valid;
  logic      head_store;
  gaddr_t    head_gaddr;
  cap_word_t head_data;

  assign busy_o = busy;

  sweep_walker #(
    .QueueDepth(QueueDepth)
  ) u_walker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .go_i         (go_i),
    .start_addr_i (start_addr_i),
    .end_addr_i   (end_addr_i),
    .load_gnt_i   (load_gnt),
    .credit_i     (credit),
    .queue_empty_i(queue_empty),
    .load_valid_o (load_valid),
    .load_gaddr_o (load_gaddr),
    .busy_o       (busy)
  );

  sweep_entry_queue #(
    .QueueDepth(QueueDepth)
  ) u_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .snoop_done_i (snoop_done_i),
    .snoop_we_i   (snoop_we_i),
    .snoop_addr_i (snoop_addr_i),
    .push_i       (push),
    .push_gaddr_i (push_gaddr),
    .rsp_wr_i     (rsp_wr),
    .rsp_data_i   (rsp_data),
    .rsp_err_i    (rsp_err),
    .rsp_revoke_i (rsp_revoke),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_store_o (head_store),
    .head_gaddr_o (head_gaddr),
    .head_data_o  (head_data),
    .empty_o      (queue_empty),
    .credit_o     (credit)
  );

  sweep_mem_sched #(
    .QueueDepth(QueueDepth)
  ) u_sched (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .busy_i          (busy),
    .load_valid_i    (load_valid),
    .load_gaddr_i    (load_gaddr),
    .load_gnt_o      (load_gnt),
    .head_valid_i    (head_valid),
    .head_store_i    (head_store),
    .head_gaddr_i    (head_gaddr),
    .head_data_i     (head_data),
    .push_o          (push),
    .push_gaddr_o    (push_gaddr),
    .rsp_wr_o        (rsp_wr),
    .rsp_data_o      (rsp_data),
    .rsp_err_o       (rsp_err),
    .rsp_revoke_o    (rsp_revoke),
    .pop_o           (pop),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_done_i      (mem_done_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_is_wr_i (mem_rsp_is_wr_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .mem_rsp_err_i   (mem_rsp_err_i),
    .mem_rsp_revoke_i(mem_rsp_revoke_i)
  );

endmodule

`default_nettype wire

/* rtl/sweep_mem_sched.sv */
// **************************************************
// sweep memory scheduler
// shares the memory port between loads and stores
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module sweep_mem_sched #(
  parameter int unsigned QueueDepth = sweep_pkg::DefaultQueueDepth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 busy_i,
  input  logic                 load_valid_i,
  input  sweep_pkg::gaddr_t    load_gaddr_i,
  output logic                 load_gnt_o,
  input  logic                 head_valid_i,
  input  logic                 head_store_i,
  input  sweep_pkg::gaddr_t    head_gaddr_i,
  input  sweep_pkg::cap_word_t head_data_i,
  output logic                 push_o,
  output sweep_pkg::gaddr_t    push_gaddr_o,
  output logic                 rsp_wr_o,
  output sweep_pkg::cap_word_t rsp_data_o,
  output logic                 rsp_err_o,
  output logic                 rsp_revoke_o,
  output logic                 pop_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [31:0]          mem_addr_o,
  output sweep_pkg::cap_word_t mem_wdata_o,
  input  logic                 mem_done_i,
  input  logic                 mem_rsp_valid_i,
  input  logic                 mem_rsp_is_wr_i,
  input  sweep_pkg::cap_word_t mem_rsp_data_i,
  input  logic                 mem_rsp_err_i,
  input  logic                 mem_rsp_revoke_i
);

  import sweep_pkg::*;

  sched_op_e op_q, op_d;
  logic      wait_rsp_q;
  logic      load_gnt;
  logic      store_gnt;
  logic      next_op_load;

  // one access in flight at a time
  assign mem_req_o = !wait_rsp_q && (((op_q == OP_LOAD) && load_valid_i) ||
                                     ((op_q == OP_STORE) && head_store_i));
  assign mem_we_o  = (op_q == OP_STORE);
  assign mem_addr_o = (op_q == OP_STORE) ? {head_gaddr_i, 3'b000} : {load_gaddr_i, 3'b000};

  // write-back is the loaded word with its tag stripped
  assign mem_wdata_o = {1'b0, head_data_i[CapW-2:0]};

  assign load_gnt  = (op_q == OP_LOAD) && mem_req_o && mem_done_i;
  assign store_gnt = (op_q == OP_STORE) && mem_req_o && mem_done_i;

  assign load_gnt_o   = load_gnt;
  assign push_o       = load_gnt;
  assign push_gaddr_o = load_gaddr_i;

  // write responses only acknowledge, load responses go to the queue
  assign rsp_wr_o     = mem_rsp_valid_i && !mem_rsp_is_wr_i;
  assign rsp_data_o   = mem_rsp_data_i;
  assign rsp_err_o    = mem_rsp_err_i;
  assign rsp_revoke_o = mem_rsp_revoke_i;

  // heads that need no write-back leave as soon as they are complete
  assign pop_o = head_valid_i && (!head_store_i || store_gnt);

  assign next_op_load = load_valid_i;

  always_comb begin
    op_d = op_q;
    if (!busy_i) begin
      op_d = OP_NONE;
    end else begin
      case (op_q)
        OP_NONE: begin
          if (load_valid_i) begin
            op_d = OP_LOAD;
          end else if (head_store_i) begin
            op_d = OP_STORE;
          end
        end
        OP_LOAD: begin
          if ((load_gnt || !load_valid_i) && head_store_i) begin
            op_d = OP_STORE;
          end else if (!load_valid_i) begin
            op_d = OP_NONE;
          end
        end
        OP_STORE: begin
          // back to loads after each write-back so the walk keeps moving
          if (store_gnt || !head_store_i) begin
            op_d = next_op_load ? OP_LOAD : OP_NONE;
          end
        end
        default: begin
          op_d = OP_NONE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q       <= OP_NONE;
      wait_rsp_q <= 1'b0;
    end else begin
      op_q <= op_d;
      if (load_gnt || store_gnt) begin
        wait_rsp_q <= 1'b1;
      end else if (mem_rsp_valid_i) begin
        wait_rsp_q <= 1'b0;
      end
    end
  end

  // memory sees at most one outstanding access
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && mem_done_i) |=> !mem_req_o);

endmodule

`default_nettype wire

/* rtl/sweep_entry_queue.sv */
// **************************************************
// sweep entry queue
// holds loaded granules, cancels on snooped stores
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module sweep_entry_queue #(
  parameter int unsigned QueueDepth = sweep_pkg::DefaultQueueDepth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 snoop_done_i,
  input  logic                 snoop_we_i,
  input  logic [31:0]          snoop_addr_i,
  input  logic                 push_i,
  input  sweep_pkg::gaddr_t    push_gaddr_i,
  input  logic                 rsp_wr_i,
  input  sweep_pkg::cap_word_t rsp_data_i,
  input  logic                 rsp_err_i,
  input  logic                 rsp_revoke_i,
  input  logic                 pop_i,
  output logic                 head_valid_o,
  output logic                 head_store_o,
  output sweep_pkg::gaddr_t    head_gaddr_o,
  output sweep_pkg::cap_word_t head_data_o,
  output logic                 empty_o,
  output logic                 credit_o
);

  import sweep_pkg::*;

  localparam int unsigned PtrW = $clog2(QueueDepth);

  // extended pointers, the extra bit tells full from empty
  logic [PtrW:0]   push_ptr_q;
  logic [PtrW:0]   rsp_ptr_q;
  logic [PtrW:0]   rd_ptr_q;
  logic [PtrW:0]   fill_cnt;
  logic [PtrW-1:0] push_idx;
  logic [PtrW-1:0] rsp_idx;
  logic [PtrW-1:0] rd_idx;

  gaddr_t            gaddr_q  [QueueDepth];
  cap_word_t         data_q   [QueueDepth];
  logic [QueueDepth-1:0] err_q;
  logic [QueueDepth-1:0] revoke_q;
  logic [QueueDepth-1:0] live_q;

  logic   snoop_store;
  gaddr_t snoop_gaddr;
  logic   snoop_hit_head;

  assign push_idx = push_ptr_q[PtrW-1:0];
  assign rsp_idx  = rsp_ptr_q[PtrW-1:0];
  assign rd_idx   = rd_ptr_q[PtrW-1:0];
  assign fill_cnt = push_ptr_q - rd_ptr_q;

  assign snoop_store = snoop_done_i && snoop_we_i;
  assign snoop_gaddr = snoop_addr_i[31:3];

  // a store landing right now on the head also kills its write-back
  assign snoop_hit_head = snoop_store && (gaddr_q[rd_idx] == snoop_gaddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_ptr_q <= '0;
      rsp_ptr_q  <= '0;
      rd_ptr_q   <= '0;
    end else begin
      if (push_i) begin
        push_ptr_q <= push_ptr_q + 1'b1;
      end
      if (rsp_wr_i) begin
        rsp_ptr_q <= rsp_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // live bit per entry, cleared by any processor store to that granule
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q <= '0;
    end else begin
      for (int i = 0; i < QueueDepth; i++) begin
        if (push_i && (push_idx == PtrW'(i))) begin
          live_q[i] <= !(snoop_store && (push_gaddr_i == snoop_gaddr));
        end else if (snoop_store && (gaddr_q[i] == snoop_gaddr)) begin
          live_q[i] <= 1'b0;
        end
      end
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      gaddr_q[push_idx] <= push_gaddr_i;
    end
    if (rsp_wr_i) begin
      data_q[rsp_idx]   <= rsp_data_i;
      err_q[rsp_idx]    <= rsp_err_i;
      revoke_q[rsp_idx] <= rsp_revoke_i;
    end
  end

  assign head_valid_o = (rd_ptr_q != rsp_ptr_q);
  assign empty_o      = (rd_ptr_q == push_ptr_q);
  assign head_gaddr_o = gaddr_q[rd_idx];
  assign head_data_o  = data_q[rd_idx];

  // write back only a tagged, revoked, error-free word nobody has touched
  assign head_store_o = head_valid_o && live_q[rd_idx] && data_q[rd_idx][CapW-1]
                        && revoke_q[rd_idx] && !err_q[rd_idx] && !snoop_hit_head;

  assign credit_o = pop_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (fill_cnt < (PtrW+1)'(QueueDepth)));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_wr_i |-> (rsp_ptr_q != push_ptr_q));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_o);

endmodule

`default_nettype wire

/* rtl/sweep_walker.sv */
// **************************************************
// sweep walker
// steps granule addresses and throttles by credits
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module sweep_walker #(
  parameter int unsigned QueueDepth = sweep_pkg::DefaultQueueDepth
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             go_i,
  input  logic [31:0]      start_addr_i,
  input  logic [31:0]      end_addr_i,
  input  logic             load_gnt_i,
  input  logic             credit_i,
  input  logic             queue_empty_i,
  output logic             load_valid_o,
  output sweep_pkg::gaddr_t load_gaddr_o,
  output logic             busy_o
);

  import sweep_pkg::*;

  localparam int unsigned CntW = $clog2(QueueDepth) + 1;
  localparam logic [CntW-1:0] FullCredit = CntW'(QueueDepth);

  sweep_state_e    state_q, state_d;
  gaddr_t          cur_gaddr_q;
  gaddr_t          end_gaddr_q;
  logic [CntW-1:0] credit_q;
  logic            last_gaddr;

  assign last_gaddr   = (cur_gaddr_q == end_gaddr_q);
  assign load_valid_o = (state_q == SWEEP_LOAD) && (credit_q != '0);
  assign load_gaddr_o = cur_gaddr_q;
  assign busy_o       = (state_q != SWEEP_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      SWEEP_IDLE: begin
        if (go_i) begin
          state_d = SWEEP_LOAD;
        end
      end
      SWEEP_LOAD: begin
        // the last granule has been handed to memory
        if (load_gnt_i && last_gaddr) begin
          state_d = SWEEP_DRAIN;
        end
      end
      SWEEP_DRAIN: begin
        if (queue_empty_i) begin
          state_d = SWEEP_IDLE;
        end
      end
      default: begin
        state_d = SWEEP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SWEEP_IDLE;
      cur_gaddr_q <= '0;
      end_gaddr_q <= '0;
      credit_q    <= FullCredit;
    end else begin
      state_q <= state_d;

      if (go_i && (state_q == SWEEP_IDLE)) begin
        cur_gaddr_q <= start_addr_i[31:3];
        end_gaddr_q <= end_addr_i[31:3];
      end else if (load_gnt_i) begin
        cur_gaddr_q <= cur_gaddr_q + 1'b1;
      end

      // a grant takes a slot, a pop from the queue gives one back
      case ({load_gnt_i, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // pops can never outnumber the loads that were granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= FullCredit);

endmodule

`default_nettype wire

/* rtl/sweep_pkg.sv */
// **************************************************
// revocation sweeper shared definitions
// widths, granule address and state/opcode encodings
// **************************************************
`default_nettype none

package sweep_pkg;

  // capability word is tag plus 32 data bits, tag on top
  parameter int unsigned CapW = 33;

  // granule address covers byte address bits 31:3
  parameter int unsigned GAddrW = 29;

  // entries in flight between walker and scheduler, power of two
  parameter int unsigned DefaultQueueDepth = 4;

  typedef logic [GAddrW-1:0] gaddr_t;

  typedef logic [CapW-1:0] cap_word_t;

  // walker progress through the address range
  typedef enum logic [1:0] {
    SWEEP_IDLE,
    SWEEP_LOAD,
    SWEEP_DRAIN
  } sweep_state_e;

  // what the scheduler currently offers on the memory port
  typedef enum logic [1:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE
  } sched_op_e;

endpackage

`default_nettype wire
